// File: hdl/video_clipper.sv
`timescale 1ns/100ps

module video_clipper import video_clipper_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// Raster in
	input  logic   in_req,
	input  pixel_t in_pix,
	output logic   in_ack,
	// Padded raster out
	output logic   out_req,
	output pixel_t out_pix,
	input  logic   out_ack
);

	// Channel between the two stages
	logic   mid_req;
	pixel_t mid_pix;
	logic   mid_ack;

	// Cut the drop margins away
	video_clipper_drop u_drop (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_req  (in_req),
		.in_pix  (in_pix),
		.in_ack  (in_ack),
		.mid_req (mid_req),
		.mid_pix (mid_pix),
		.mid_ack (mid_ack)
	);

	// Wrap the window in a pad border
	video_clipper_add u_add (
		.clk     (clk),
		.arst_n  (arst_n),
		.mid_req (mid_req),
		.mid_pix (mid_pix),
		.mid_ack (mid_ack),
		.out_req (out_req),
		.out_pix (out_pix),
		.out_ack (out_ack)
	);

endmodule

// File: hdl/video_clipper_add.sv
`timescale 1ns/100ps

module video_clipper_add import video_clipper_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// Channel from the drop stage
	input  logic   mid_req,
	input  pixel_t mid_pix,
	output logic   mid_ack,
	// Output channel
	output logic   out_req,
	output pixel_t out_pix,
	input  logic   out_ack
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_FETCH,
		ST_PRESENT,
		ST_RELEASE
	} state_t;

	state_t state;
	logic   advance;
	logic   take_mid;
	logic   take_pad;
	logic   sof_outer;
	logic   eof_outer;
	logic   in_window;

	// Output handshake finished, move to next position
	assign advance = (state == ST_RELEASE) & ~out_ack;

	// Fresh pixel offered by the drop stage
	assign take_mid = (state == ST_FETCH) & mid_req & ~mid_ack;

	// Border position, no input needed
	assign take_pad = (state == ST_IDLE) & ~in_window;

	// Output raster position
	video_clipper_counters #(
		.IMAGE_WIDTH   (OUT_WIDTH),
		.IMAGE_HEIGHT  (OUT_HEIGHT),
		.LEFT_OFFSET   (ADD_LEFT),
		.RIGHT_OFFSET  (ADD_RIGHT),
		.TOP_OFFSET    (ADD_TOP),
		.BOTTOM_OFFSET (ADD_BOTTOM)
	) u_counters (
		.clk                  (clk),
		.arst_n               (arst_n),
		.advance              (advance),
		.start_of_outer_frame (sof_outer),
		.end_of_outer_frame   (eof_outer),
		.start_of_inner_frame (),
		.end_of_inner_frame   (),
		.inner_frame_valid    (in_window)
	);

	// Position FSM and output request
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			out_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (in_window)
						state <= ST_FETCH;
					else begin
						out_req <= 1'b1;
						state   <= ST_PRESENT;
					end
				end
				ST_FETCH: begin
					// Wait for the next window pixel
					if (take_mid) begin
						out_req <= 1'b1;
						state   <= ST_PRESENT;
					end
				end
				ST_PRESENT: begin
					if (out_ack) begin
						out_req <= 1'b0;
						state   <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					// Counter steps on the falling ack
					if (!out_ack)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Mid ack: up when pixel taken, down after req drops
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mid_ack <= 1'b0;
		else if (mid_ack) begin
			if (!mid_req)
				mid_ack <= 1'b0;
		end else if (take_mid) begin
			mid_ack <= 1'b1;
		end
	end

	// Output payload, framing from the outer flags
	always_ff @(posedge clk) begin
		if (take_pad || take_mid) begin
			out_pix.data <= take_mid ? mid_pix.data : PAD_COLOR;
			out_pix.sop  <= sof_outer;
			out_pix.eop  <= eof_outer;
		end
	end

endmodule

// File: hdl/video_clipper_counters.sv
`timescale 1ns/100ps

module video_clipper_counters #(
	parameter int IMAGE_WIDTH   = 16,
	parameter int IMAGE_HEIGHT  = 12,
	parameter int LEFT_OFFSET   = 0,
	parameter int RIGHT_OFFSET  = 0,
	parameter int TOP_OFFSET    = 0,
	parameter int BOTTOM_OFFSET = 0
) (
	input  logic clk,
	input  logic arst_n,
	input  logic advance,
	output logic start_of_outer_frame,
	output logic end_of_outer_frame,
	output logic start_of_inner_frame,
	output logic end_of_inner_frame,
	output logic inner_frame_valid
);

	// Counter widths from the frame size
	localparam int WW = (IMAGE_WIDTH > 1) ? $clog2(IMAGE_WIDTH) : 1;
	localparam int HW = (IMAGE_HEIGHT > 1) ? $clog2(IMAGE_HEIGHT) : 1;

	// Column boundaries
	localparam logic [WW-1:0] COL_LAST       = WW'(IMAGE_WIDTH - 1);
	localparam logic [WW-1:0] COL_IN_FIRST   = WW'(LEFT_OFFSET);
	localparam logic [WW-1:0] COL_IN_LAST    = WW'(IMAGE_WIDTH - RIGHT_OFFSET - 1);
	localparam logic [WW-1:0] COL_PRE_INNER  = WW'(LEFT_OFFSET - 1);
	// Row boundaries
	localparam logic [HW-1:0] ROW_LAST       = HW'(IMAGE_HEIGHT - 1);
	localparam logic [HW-1:0] ROW_IN_FIRST   = HW'(TOP_OFFSET);
	localparam logic [HW-1:0] ROW_IN_LAST    = HW'(IMAGE_HEIGHT - BOTTOM_OFFSET - 1);
	localparam logic [HW-1:0] ROW_PRE_INNER  = HW'(TOP_OFFSET - 1);

	logic [WW-1:0] col;
	logic [HW-1:0] row;
	logic          inner_width_valid;
	logic          inner_height_valid;
	logic          line_end;

	// Last pixel of a line is being consumed
	assign line_end = advance & (col == COL_LAST);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			col <= '0;
			row <= '0;
		end else if (line_end) begin
			col <= '0;
			// Whole frame done, back to top left
			if (row == ROW_LAST)
				row <= '0;
			else
				row <= row + 1'b1;
		end else if (advance) begin
			col <= col + 1'b1;
		end
	end

	// Horizontal window bit, set one step before the first inner column
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			inner_width_valid <= (LEFT_OFFSET == 0);
		else if (advance) begin
			if (col == COL_LAST)
				inner_width_valid <= (LEFT_OFFSET == 0);
			else if (col == COL_IN_LAST)
				inner_width_valid <= 1'b0;
			else if ((LEFT_OFFSET != 0) && (col == COL_PRE_INNER))
				inner_width_valid <= 1'b1;
		end
	end

	// Vertical window bit, only moves at line ends
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			inner_height_valid <= (TOP_OFFSET == 0);
		else if (line_end) begin
			if (row == ROW_LAST)
				inner_height_valid <= (TOP_OFFSET == 0);
			else if (row == ROW_IN_LAST)
				inner_height_valid <= 1'b0;
			else if ((TOP_OFFSET != 0) && (row == ROW_PRE_INNER))
				inner_height_valid <= 1'b1;
		end
	end

	// Position flags, combinational from the counters
	assign start_of_outer_frame = (col == '0) & (row == '0);
	assign end_of_outer_frame   = (col == COL_LAST) & (row == ROW_LAST);
	assign start_of_inner_frame = (col == COL_IN_FIRST) & (row == ROW_IN_FIRST);
	assign end_of_inner_frame   = (col == COL_IN_LAST) & (row == ROW_IN_LAST);
	assign inner_frame_valid    = inner_width_valid & inner_height_valid;

endmodule

// File: hdl/video_clipper_drop.sv
`timescale 1ns/100ps

module video_clipper_drop import video_clipper_pkg::*; (
	input  logic   clk,
	input  logic   arst_n,
	// Input channel
	input  logic   in_req,
	input  pixel_t in_pix,
	output logic   in_ack,
	// Channel towards the add stage
	output logic   mid_req,
	output pixel_t mid_pix,
	input  logic   mid_ack
);

	logic   accept;
	logic   hold_valid;
	pixel_t hold_pix;
	logic   sof_inner;
	logic   eof_inner;
	logic   in_window;
	logic   mid_done;

	// New request, previous ack gone and room to store
	assign accept = in_req & ~in_ack & ~hold_valid;

	// Handshake on mid channel completes
	assign mid_done = mid_req & mid_ack;

	// Input raster position
	video_clipper_counters #(
		.IMAGE_WIDTH   (IN_WIDTH),
		.IMAGE_HEIGHT  (IN_HEIGHT),
		.LEFT_OFFSET   (DROP_LEFT),
		.RIGHT_OFFSET  (DROP_RIGHT),
		.TOP_OFFSET    (DROP_TOP),
		.BOTTOM_OFFSET (DROP_BOTTOM)
	) u_counters (
		.clk                  (clk),
		.arst_n               (arst_n),
		.advance              (accept),
		.start_of_outer_frame (),
		.end_of_outer_frame   (),
		.start_of_inner_frame (sof_inner),
		.end_of_inner_frame   (eof_inner),
		.inner_frame_valid    (in_window)
	);

	// Input ack: up on accept, down once req drops
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			in_ack <= 1'b0;
		else if (in_ack) begin
			if (!in_req)
				in_ack <= 1'b0;
		end else if (accept) begin
			in_ack <= 1'b1;
		end
	end

	// Holding register state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			hold_valid <= 1'b0;
		else if (accept && in_window)
			hold_valid <= 1'b1;
		else if (mid_done)
			// Add stage has taken the pixel
			hold_valid <= 1'b0;
	end

	// Pixel payload, window pixels only
	always_ff @(posedge clk) begin
		if (accept && in_window) begin
			hold_pix.data <= in_pix.data;
			hold_pix.sop  <= sof_inner;
			hold_pix.eop  <= eof_inner;
		end
	end

	// Mid request, never raised while the old ack is still high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			mid_req <= 1'b0;
		else if (mid_done)
			mid_req <= 1'b0;
		else if (!mid_req && hold_valid && !mid_ack)
			mid_req <= 1'b1;
	end

	// Holding register drives the mid channel
	assign mid_pix = hold_pix;

endmodule

// File: hdl/video_clipper_pkg.sv
package video_clipper_pkg;

	// One pixel on any of the req/ack channels
	typedef struct packed {
		logic [23:0] data;
		// First pixel of a frame
		logic        sop;
		// Last pixel of a frame
		logic        eop;
	} pixel_t;

	// Input raster size
	localparam int IN_WIDTH  = 16;
	localparam int IN_HEIGHT = 12;

	// Margins cut away from the input raster
	localparam int DROP_LEFT   = 2;
	localparam int DROP_RIGHT  = 3;
	localparam int DROP_TOP    = 1;
	localparam int DROP_BOTTOM = 2;

	// Window that survives the drop stage
	localparam int KEEP_WIDTH  = IN_WIDTH - DROP_LEFT - DROP_RIGHT;
	localparam int KEEP_HEIGHT = IN_HEIGHT - DROP_TOP - DROP_BOTTOM;

	// Pad border put around the kept window
	localparam int ADD_LEFT   = 1;
	localparam int ADD_RIGHT  = 0;
	localparam int ADD_TOP    = 0;
	localparam int ADD_BOTTOM = 1;

	// Output raster size
	localparam int OUT_WIDTH  = KEEP_WIDTH + ADD_LEFT + ADD_RIGHT;
	localparam int OUT_HEIGHT = KEEP_HEIGHT + ADD_TOP + ADD_BOTTOM;

	// RGB value of every border pixel
	localparam logic [23:0] PAD_COLOR = 24'h102030;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the video clipper testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module video_clipper_tb \
	-f video_clipper.f \
	-Mdir "$build_dir" -o video_clipper_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/video_clipper_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

# Verdict is taken from the simulation log
if grep -q "TESTS FAILED" "$log_file"; then
	exit 1
fi
exit 0

// File: testbench/video_clipper_asserts.sv
`timescale 1ns/100ps

module video_clipper_asserts import video_clipper_pkg::*; (
	input logic   clk,
	input logic   arst_n,
	input logic   req,
	input pixel_t pix,
	input logic   ack
);

	// Payload frozen while req waits for ack
	pix_stable: assert property (@(posedge clk) disable iff (!arst_n)
		$past(req && !ack) |-> $stable(pix))
		else $error("pix changed while req was waiting for ack");

	// New req only once the previous ack has gone
	req_after_ack: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(req) |-> !$past(ack))
		else $error("req rose while ack was still high");

	// Ack answers a req seen now or one cycle back
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> (req || $past(req)))
		else $error("ack rose without a req");

endmodule

bind video_clipper_drop video_clipper_asserts u_in_channel_asserts (
	.clk (clk), .arst_n (arst_n), .req (in_req), .pix (in_pix), .ack (in_ack)
);

bind video_clipper_drop video_clipper_asserts u_mid_channel_asserts (
	.clk (clk), .arst_n (arst_n), .req (mid_req), .pix (mid_pix), .ack (mid_ack)
);

bind video_clipper_add video_clipper_asserts u_out_channel_asserts (
	.clk (clk), .arst_n (arst_n), .req (out_req), .pix (out_pix), .ack (out_ack)
);

// File: testbench/video_clipper_tb.sv
`timescale 1ns/100ps

module video_clipper_tb import video_clipper_pkg::*; ();

	localparam int          CLK_PERIOD   = 100;
	localparam int          RESET_CYCLES = 10;
	// Longest single wait, in clock cycles
	localparam int          WAIT_LIMIT   = 2000;
	localparam int          MAX_FRAMES   = 3;
	localparam logic [31:0] LFSR_SEED    = 32'ha237;
	localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

	logic   clk;
	logic   arst_n;
	logic   in_req;
	pixel_t in_pix;
	logic   in_ack;
	logic   out_req;
	pixel_t out_pix;
	logic   out_ack;

	// Input frames, rebuilt before each test
	logic [23:0] src [MAX_FRAMES][IN_HEIGHT][IN_WIDTH];
	logic [31:0] data_lfsr;
	logic [31:0] delay_lfsr;
	int          errors;
	int          tests_run;
	int          tests_failed;
	int          sop_count;
	int          eop_count;

	video_clipper u_video_clipper (
		.clk     (clk),
		.arst_n  (arst_n),
		.in_req  (in_req),
		.in_pix  (in_pix),
		.in_ack  (in_ack),
		.out_req (out_req),
		.out_pix (out_pix),
		.out_ack (out_ack)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Galois form, shift right
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// One step per bit taken
	task automatic draw_bits(input int n, inout logic [31:0] state, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	task automatic fill_frames(input bit use_lfsr);
		logic [31:0] value;
		for (int f = 0; f < MAX_FRAMES; f++)
			for (int r = 0; r < IN_HEIGHT; r++)
				for (int c = 0; c < IN_WIDTH; c++) begin
					draw_bits(use_lfsr ? 24 : 0, data_lfsr, value);
					// Position code is row, column, frame from high to low byte
					src[f][r][c] = use_lfsr ? value[23:0] : {8'(r), 8'(c), 8'(f)};
				end
	endtask

	// Output position to pixel, border gets pad colour
	function automatic pixel_t expected_pixel(input int f, input int r, input int c);
		pixel_t p;
		bit     in_win;
		in_win = (c >= ADD_LEFT) && (c < ADD_LEFT + KEEP_WIDTH) &&
			(r >= ADD_TOP) && (r < ADD_TOP + KEEP_HEIGHT);
		p.data = in_win ? src[f][r - ADD_TOP + DROP_TOP][c - ADD_LEFT + DROP_LEFT] : PAD_COLOR;
		p.sop  = (r == 0) && (c == 0);
		p.eop  = (r == OUT_HEIGHT - 1) && (c == OUT_WIDTH - 1);
		return p;
	endfunction

	task automatic report_timeout(input string what);
		$display("Timeout: %s did not happen within %0d cycles", what, WAIT_LIMIT);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: data %h sop %h eop %h, expected data %h sop %h eop %h",
				name, got.data, got.sop, got.eop, exp.data, exp.sop, exp.eop);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Mismatch %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic send_frames(input int nframes);
		int wait_cnt;
		for (int f = 0; f < nframes; f++)
			for (int r = 0; r < IN_HEIGHT; r++)
				for (int c = 0; c < IN_WIDTH; c++) begin
					@(negedge clk);
					in_pix.data = src[f][r][c];
					in_pix.sop  = (r == 0) && (c == 0);
					in_pix.eop  = (r == IN_HEIGHT - 1) && (c == IN_WIDTH - 1);
					in_req      = 1'b1;
					wait_cnt    = 0;
					while (!in_ack) begin
						@(negedge clk);
						wait_cnt++;
						if (wait_cnt > WAIT_LIMIT)
							report_timeout("in_ack rise");
					end
					in_req   = 1'b0;
					wait_cnt = 0;
					while (in_ack) begin
						@(negedge clk);
						wait_cnt++;
						if (wait_cnt > WAIT_LIMIT)
							report_timeout("in_ack fall");
					end
				end
	endtask

	// Ack every output, optionally after 0 to 7 idle cycles
	task automatic receive_frames(input int nframes, input bit delayed);
		int          wait_cnt;
		logic [31:0] delay;
		sop_count = 0;
		eop_count = 0;
		for (int f = 0; f < nframes; f++)
			for (int r = 0; r < OUT_HEIGHT; r++)
				for (int c = 0; c < OUT_WIDTH; c++) begin
					wait_cnt = 0;
					while (!out_req) begin
						@(negedge clk);
						wait_cnt++;
						if (wait_cnt > WAIT_LIMIT)
							report_timeout("out_req rise");
					end
					check_pixel("out_pix", out_pix, expected_pixel(f, r, c));
					if (out_pix.sop)
						sop_count++;
					if (out_pix.eop)
						eop_count++;
					draw_bits(delayed ? 3 : 0, delay_lfsr, delay);
					repeat (delay) @(negedge clk);
					out_ack  = 1'b1;
					wait_cnt = 0;
					while (out_req) begin
						@(negedge clk);
						wait_cnt++;
						if (wait_cnt > WAIT_LIMIT)
							report_timeout("out_req fall");
					end
					out_ack = 1'b0;
				end
	endtask

	task automatic end_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before) begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, errors - errs_before);
		end else
			$display("%s: ok", name);
	endtask

	task automatic test_reset_quiet();
		int errs;
		errs   = errors;
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		check_flag("in_ack", in_ack, 1'b0);
		check_flag("out_req", out_req, 1'b0);
		arst_n = 1'b1;
		// Border pixel at 0,0 may go out at once, input side stays quiet
		repeat (20) begin
			@(negedge clk);
			check_flag("in_ack", in_ack, 1'b0);
			check_flag("mid_req", u_video_clipper.mid_req, 1'b0);
		end
		end_test("reset_quiet", errs);
	endtask

	task automatic run_frames(input string name, input bit use_lfsr, input int nframes,
		input bit delayed);
		int errs;
		int wait_cnt;
		errs       = errors;
		data_lfsr  = LFSR_SEED;
		delay_lfsr = LFSR_SEED;
		fill_frames(use_lfsr);
		fork
			send_frames(nframes);
			receive_frames(nframes, delayed);
		join
		check_count("sop count", sop_count, nframes);
		check_count("eop count", eop_count, nframes);
		// Nothing left over, next output opens a new frame
		wait_cnt = 0;
		while (!out_req) begin
			@(negedge clk);
			wait_cnt++;
			if (wait_cnt > WAIT_LIMIT)
				report_timeout("next frame start");
		end
		check_flag("out_pix.sop", out_pix.sop, 1'b1);
		check_flag("mid_req", u_video_clipper.mid_req, 1'b0);
		end_test(name, errs);
	endtask

	initial begin
		clk          = 1'b0;
		arst_n       = 1'b0;
		in_req       = 1'b0;
		in_pix       = '0;
		out_ack      = 1'b0;
		data_lfsr    = LFSR_SEED;
		delay_lfsr   = LFSR_SEED;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		test_reset_quiet();
		run_frames("single_frame", 1'b0, 1, 1'b0);
		// Two frames so sop and eop are seen on both sides of a frame boundary
		run_frames("frame_markers", 1'b0, 2, 1'b0);
		run_frames("lfsr_frames", 1'b1, 3, 1'b0);
		run_frames("backpressure", 1'b1, 3, 1'b1);
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (tests_failed == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: video_clipper.f
hdl/video_clipper_pkg.sv
hdl/video_clipper_counters.sv
hdl/video_clipper_drop.sv
hdl/video_clipper_add.sv
hdl/video_clipper.sv
testbench/video_clipper_asserts.sv
testbench/video_clipper_tb.sv
